/* Makefile */
# Verilator build and run for the NAND sync data-out stage

VERILATOR ?= verilator
TOP       ?= tbNandSyncDataOut
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+src
src/nandOutPkg.sv
src/dataOutSequencer.sv
src/dqOutputPipe.sv
src/nandSyncDataOut.sv
test/tbClockGen.sv
test/tbNandSyncDataOut.sv

/* src/dataOutSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nandOut_params.svh"

module dataOutSequencer #(
    parameter int NumberOfWays = `NAND_WAYS
) (
    input  wire                            iSystemClock,
    input  wire                            iReset,
    input  wire                            iStart,
    input  wire  [NumberOfWays-1:0]        iTargetWay,
    input  wire  [`BYTE_COUNT_BITS-1:0]    iNumOfData,
    input  wire  [`DATA_WORD_BITS-1:0]     iWriteData,
    input  wire                            iWriteValid,
    output logic                           oReady,
    output logic                           oLastStep,
    output logic                           oWriteReady,
    output logic [2*NumberOfWays-1:0]      oChipEnable,
    output logic [`PIN_PHASES-1:0]         oWriteEnable,
    output logic                           beatValid,
    output logic [`DATA_WORD_BITS-1:0]     beatWord
);

    // one timer serves both waits, sized for the longer one
    localparam int TimerBits = $clog2((`WPST_CYCLES > `TDQSS_CYCLES ?
                                       `WPST_CYCLES : `TDQSS_CYCLES) + 1);
    localparam logic [TimerBits-1:0] PreambleLast  = `TDQSS_CYCLES - 1;
    localparam logic [TimerBits-1:0] PostambleLast = `WPST_CYCLES - 1;
    localparam logic [`BYTE_COUNT_BITS-1:0] BytesPerWord = `DATA_WORD_BITS / 8;

    nandOutPkg::seqStateT state;
    nandOutPkg::seqStateT nextState;

    logic [TimerBits-1:0]          timer;
    logic [TimerBits-1:0]          nextTimer;
    logic [NumberOfWays-1:0]       targetWay;
    logic [`BYTE_COUNT_BITS-1:0]   numOfData;
    logic [`BYTE_COUNT_BITS-1:0]   byteCount;
    logic [`BYTE_COUNT_BITS-1:0]   nextByteCount;

    logic startAccept;
    logic wordAccept;
    logic dataDone;
    logic chipActive;
    logic writeActive;

    assign startAccept   = iStart & oReady;
    assign wordAccept    = iWriteValid & oWriteReady;
    assign nextByteCount = byteCount + BytesPerWord;
    assign dataDone      = (nextByteCount == numOfData);  // this word closes the transfer

    always_comb begin
        nextState = state;
        nextTimer = '0;
        case (state)
            nandOutPkg::stateReset: begin
                nextState = nandOutPkg::stateReady;
            end
            nandOutPkg::stateReady: begin
                if (startAccept) begin
                    nextState = nandOutPkg::stateLatch;
                end
            end
            nandOutPkg::stateLatch: begin
                nextState = nandOutPkg::statePreamble;
            end
            nandOutPkg::statePreamble: begin
                if (timer == PreambleLast) begin
                    nextState = nandOutPkg::stateData;
                end else begin
                    nextTimer = timer + 1'b1;
                end
            end
            nandOutPkg::stateData: begin
                if (wordAccept && dataDone) begin
                    nextState = nandOutPkg::statePostamble;
                end
            end
            nandOutPkg::statePostamble: begin
                if (timer == PostambleLast) begin
                    nextState = nandOutPkg::stateReady;
                end else begin
                    nextTimer = timer + 1'b1;
                end
            end
            default: begin
                nextState = nandOutPkg::stateReady;
            end
        endcase
    end

    // pin activity as seen in the coming cycle
    assign chipActive  = nextState inside {nandOutPkg::statePreamble, nandOutPkg::stateData,
                                           nandOutPkg::statePostamble};
    assign writeActive = chipActive || (nextState == nandOutPkg::stateLatch);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= nandOutPkg::stateReset;
            timer <= '0;
        end else begin
            state <= nextState;
            timer <= nextTimer;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            targetWay <= '0;
            numOfData <= '0;
            byteCount <= '0;
        end else if (startAccept) begin
            targetWay <= iTargetWay;
            numOfData <= iNumOfData;
            byteCount <= '0;
        end else if (wordAccept) begin
            byteCount <= nextByteCount;  // two bytes per word
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oReady       <= 1'b0;
            oLastStep    <= 1'b0;
            oWriteReady  <= 1'b0;
            oChipEnable  <= '0;
            oWriteEnable <= '0;
            beatValid    <= 1'b0;
        end else begin
            oReady      <= (nextState == nandOutPkg::stateReady);
            oWriteReady <= (nextState == nandOutPkg::stateData);
            // high through the final postamble cycle
            oLastStep   <= (nextState == nandOutPkg::statePostamble) &&
                           (nextTimer == PostambleLast);
            oChipEnable  <= chipActive ? {targetWay, targetWay} : '0;
            oWriteEnable <= writeActive ? `WE_WRITE_PATTERN : '0;
            beatValid    <= wordAccept;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (wordAccept) begin
            beatWord <= iWriteData;
        end
    end

endmodule

`default_nettype wire

/* src/dqOutputPipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nandOut_params.svh"

module dqOutputPipe (
    input  wire                          iSystemClock,
    input  wire                          iReset,
    input  wire                          beatValid,
    input  wire  nandOutPkg::dataWordT   beatWord,
    output logic [`DATA_WORD_BITS-1:0]   oDQ,
    output logic [`DQS_PHASES-1:0]       oDQStrobe,
    output logic [`PIN_PHASES-1:0]       oAddressLatchEnable,
    output logic [`PIN_PHASES-1:0]       oCommandLatchEnable
);

    localparam int LastStage = `DQ_DELAY_STAGES - 1;

    nandOutPkg::dataWordT          orderedWord;
    nandOutPkg::dataWordT          dqLine  [`DQ_DELAY_STAGES];
    logic [`DQS_PHASES-1:0]        dqsLine [`DQ_DELAY_STAGES];
    logic [`PIN_PHASES-1:0]        aleLine [`DQ_DELAY_STAGES];
    logic [`PIN_PHASES-1:0]        cleLine [`DQ_DELAY_STAGES];

    // serializer shifts the upper half out first, so the low byte goes there
    always_comb begin
        orderedWord.bytes.high = beatWord.bytes.low;
        orderedWord.bytes.low  = beatWord.bytes.high;
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            for (int i = 0; i < `DQ_DELAY_STAGES; i++) begin
                dqLine[i]  <= '0;
                dqsLine[i] <= '0;
                aleLine[i] <= '0;
                cleLine[i] <= '0;
            end
        end else begin
            // idle beats load zeros
            dqLine[0]  <= beatValid ? orderedWord : '0;
            dqsLine[0] <= beatValid ? `DQS_DATA_PATTERN : '0;
            aleLine[0] <= beatValid ? `ALE_DATA_MARK : '0;  // ALE+CLE high marks data
            cleLine[0] <= beatValid ? `CLE_DATA_MARK : '0;
            for (int i = 1; i < `DQ_DELAY_STAGES; i++) begin
                dqLine[i]  <= dqLine[i-1];
                dqsLine[i] <= dqsLine[i-1];
                aleLine[i] <= aleLine[i-1];
                cleLine[i] <= cleLine[i-1];
            end
        end
    end

    assign oDQ                 = dqLine[LastStage].raw;
    assign oDQStrobe           = dqsLine[LastStage];
    assign oAddressLatchEnable = aleLine[LastStage];
    assign oCommandLatchEnable = cleLine[LastStage];

endmodule

`default_nettype wire

/* src/nandOutPkg.sv */
`default_nettype none

`include "nandOut_params.svh"

package nandOutPkg;

    typedef struct packed {
        logic [7:0] high;
        logic [7:0] low;
    } byteViewT;

    // one write word, seen as a whole or byte by byte
    typedef union packed {
        logic [`DATA_WORD_BITS-1:0] raw;
        byteViewT                   bytes;
    } dataWordT;

    // one-hot sequencer states
    typedef enum logic [5:0] {
        stateReset     = 6'b000001,
        stateReady     = 6'b000010,
        stateLatch     = 6'b000100,  // request capture
        statePreamble  = 6'b001000,  // tDQSS
        stateData      = 6'b010000,
        statePostamble = 6'b100000   // write postamble
    } seqStateT;

endpackage

`default_nettype wire

/* src/nandOut_params.svh */
`ifndef NANDOUT_PARAMS_SVH
`define NANDOUT_PARAMS_SVH

// channel geometry
`define NAND_WAYS           4
`define DATA_WORD_BITS      16
`define BYTE_COUNT_BITS     16

// serializer phases per clock
`define PIN_PHASES          4
`define DQS_PHASES          2

// pin patterns, widths follow the phase counts above
`define WE_WRITE_PATTERN    4'b0001
`define DQS_DATA_PATTERN    2'b11
`define ALE_DATA_MARK       4'b0011
`define CLE_DATA_MARK       4'b0011

// waits in system clock cycles
`define TDQSS_CYCLES        3
`define WPST_CYCLES         6
`define DQ_DELAY_STAGES     2   // pad serializer latency

`endif

/* src/nandSyncDataOut.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nandOut_params.svh"

module nandSyncDataOut #(
    parameter int NumberOfWays = `NAND_WAYS
) (
    input  wire                           iSystemClock,
    input  wire                           iReset,

    // command side
    input  wire                           iStart,
    input  wire [NumberOfWays-1:0]        iTargetWay,
    input  wire [`BYTE_COUNT_BITS-1:0]    iNumOfData,
    output wire                           oReady,
    output wire                           oLastStep,

    // write data
    input  wire [`DATA_WORD_BITS-1:0]     iWriteData,
    input  wire                           iWriteValid,
    output wire                           oWriteReady,

    // NAND pins, through the pad serializers
    output wire [`DATA_WORD_BITS-1:0]     oDQ,
    output wire [`DQS_PHASES-1:0]         oDQStrobe,
    output wire [2*NumberOfWays-1:0]      oChipEnable,
    output wire [`PIN_PHASES-1:0]         oWriteEnable,
    output wire [`PIN_PHASES-1:0]         oAddressLatchEnable,
    output wire [`PIN_PHASES-1:0]         oCommandLatchEnable
);

    wire                         beatValid;
    wire [`DATA_WORD_BITS-1:0]   beatWord;   // accepted word, one cycle after the edge

    dataOutSequencer #(
        .NumberOfWays (NumberOfWays)
    ) sequencer (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .iWriteData   (iWriteData),
        .iWriteValid  (iWriteValid),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oWriteReady  (oWriteReady),
        .oChipEnable  (oChipEnable),
        .oWriteEnable (oWriteEnable),
        .beatValid    (beatValid),
        .beatWord     (beatWord)
    );

    // DQ, strobe and data-phase marks share one delay line
    dqOutputPipe outputPipe (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .beatValid           (beatValid),
        .beatWord            (beatWord),
        .oDQ                 (oDQ),
        .oDQStrobe           (oDQStrobe),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oCommandLatchEnable (oCommandLatchEnable)
    );

endmodule

`default_nettype wire

/* test/tbClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int HalfPeriod  = 10,  // ns, 20 ns period
    parameter int ResetCycles = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;  // release away from the active edge
    end

    always #HalfPeriod clock = ~clock;

endmodule

`default_nettype wire

/* test/tbNandSyncDataOut.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nandOut_params.svh"

module tbNandSyncDataOut;

    localparam int Ways        = `NAND_WAYS;
    localparam int ResetCycles = 10;
    localparam int MaxGap      = 3;
    localparam int IdleCycles  = 12;
    localparam int TotalWords  = 1 + 8 + 12 + 3 * 4;  // words over all tests
    localparam int Transfers   = 6;
    localparam int TransferWait = 2 + `TDQSS_CYCLES + `WPST_CYCLES + `DQ_DELAY_STAGES + 4;
    // twice the worst case as margin
    localparam int CycleLimit  = 2 * (ResetCycles + 10 + TotalWords * (MaxGap + 1)
                                      + Transfers * (TransferWait + IdleCycles));

    wire                           iSystemClock;
    wire                           iReset;
    logic                          iStart;
    logic [Ways-1:0]               iTargetWay;
    logic [`BYTE_COUNT_BITS-1:0]   iNumOfData;
    logic [`DATA_WORD_BITS-1:0]    iWriteData;
    logic                          iWriteValid;
    wire                           oReady;
    wire                           oLastStep;
    wire                           oWriteReady;
    wire [`DATA_WORD_BITS-1:0]     oDQ;
    wire [`DQS_PHASES-1:0]         oDQStrobe;
    wire [2*Ways-1:0]              oChipEnable;
    wire [`PIN_PHASES-1:0]         oWriteEnable;
    wire [`PIN_PHASES-1:0]         oAddressLatchEnable;
    wire [`PIN_PHASES-1:0]         oCommandLatchEnable;

    int cycleCount = 0;
    int lastStepCount = 0;
    nandOutPkg::dataWordT          sentWords[$];
    int                            sentCycles[$];   // accepting edge per word
    logic [`DATA_WORD_BITS-1:0]    seenDQ[$];
    int                            seenCycles[$];

    tbClockGen #(
        .ResetCycles (ResetCycles)
    ) clockGen (
        .clock (iSystemClock),
        .reset (iReset)
    );

    nandSyncDataOut #(
        .NumberOfWays (Ways)
    ) dut (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .iStart              (iStart),
        .iTargetWay          (iTargetWay),
        .iNumOfData          (iNumOfData),
        .oReady              (oReady),
        .oLastStep           (oLastStep),
        .iWriteData          (iWriteData),
        .iWriteValid         (iWriteValid),
        .oWriteReady         (oWriteReady),
        .oDQ                 (oDQ),
        .oDQStrobe           (oDQStrobe),
        .oChipEnable         (oChipEnable),
        .oWriteEnable        (oWriteEnable),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oCommandLatchEnable (oCommandLatchEnable)
    );

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // posedge count, also bounds the run
    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run hung and did not finish within %0d cycles", CycleLimit);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    // pin monitor, samples mid-cycle
    always @(negedge iSystemClock) begin
        if (!iReset) begin
            if (oLastStep) begin
                lastStepCount++;
            end
            if (oDQStrobe != '0) begin
                checkValue(32'(oDQStrobe), 32'(`DQS_DATA_PATTERN), "strobe on a data beat");
                checkValue(32'(oAddressLatchEnable), 32'(`ALE_DATA_MARK), "ALE on a data beat");
                checkValue(32'(oCommandLatchEnable), 32'(`CLE_DATA_MARK), "CLE on a data beat");
                seenDQ.push_back(oDQ);
                seenCycles.push_back(cycleCount);
            end else begin
                checkValue(32'(oDQ), 0, "DQ while idle");
                checkValue(32'(oAddressLatchEnable), 0, "ALE while idle");
                checkValue(32'(oCommandLatchEnable), 0, "CLE while idle");
            end
        end
    end

    task automatic checkIdleOutputs(input string when);
        checkValue(32'(oReady), 0, {"ready ", when});
        checkValue(32'(oWriteReady), 0, {"write ready ", when});
        checkValue(32'(oLastStep), 0, {"last step ", when});
        checkValue(32'(oChipEnable), 0, {"chip enable ", when});
        checkValue(32'(oWriteEnable), 0, {"write enable ", when});
        checkValue(32'(oAddressLatchEnable), 0, {"ALE ", when});
        checkValue(32'(oCommandLatchEnable), 0, {"CLE ", when});
        checkValue(32'(oDQStrobe), 0, {"strobe ", when});
        checkValue(32'(oDQ), 0, {"DQ ", when});
    endtask

    task automatic compareBeats();
        nandOutPkg::dataWordT expected;
        checkValue(seenDQ.size(), sentWords.size(), "number of DQ beats");
        foreach (sentWords[i]) begin
            expected.bytes.high = sentWords[i].bytes.low;  // low byte leads on the pins
            expected.bytes.low  = sentWords[i].bytes.high;
            checkValue(32'(seenDQ[i]), 32'(expected.raw), "DQ beat data");
            checkValue(seenCycles[i], sentCycles[i] + `DQ_DELAY_STAGES, "DQ beat latency");
        end
    endtask

    task automatic runTransfer(input logic [Ways-1:0] way, input int numWords,
                               input int maxGap, input bit strayStart);
        nandOutPkg::dataWordT word;
        logic [2*Ways-1:0] chipMask;
        int startCycle;
        int lastAccept;
        int stepsBefore;
        int gap;
        bit accepted;
        chipMask = {way, way};
        stepsBefore = lastStepCount;
        sentWords.delete();
        sentCycles.delete();
        seenDQ.delete();
        seenCycles.delete();
        while (!oReady) begin
            @(negedge iSystemClock);
        end
        iStart     = 1'b1;
        iTargetWay = way;
        iNumOfData = 16'(2 * numWords);
        startCycle = cycleCount + 1;
        @(negedge iSystemClock);
        iStart     = 1'b0;
        iTargetWay = '0;  // request must already be latched
        iNumOfData = '0;
        checkValue(32'(oReady), 0, "ready in latch cycle");
        checkValue(32'(oWriteEnable), 32'(`WE_WRITE_PATTERN), "write enable in latch cycle");
        checkValue(32'(oChipEnable), 0, "chip enable in latch cycle");
        @(negedge iSystemClock);
        checkValue(32'(oChipEnable), 32'(chipMask), "chip enable in first preamble cycle");
        if (strayStart) begin
            iStart     = 1'b1;
            iTargetWay = ~way;
            iNumOfData = 16'd2;
            @(negedge iSystemClock);
            iStart     = 1'b0;
            iTargetWay = '0;
            iNumOfData = '0;
        end
        for (int n = 0; n < numWords; n++) begin
            word.raw = 16'($urandom());
            gap = (n == 0) ? 0 : $urandom_range(0, maxGap);
            repeat (gap) begin
                iWriteValid = 1'b0;
                @(negedge iSystemClock);
                checkValue(32'(oChipEnable), 32'(chipMask), "chip enable in a source gap");
            end
            iWriteValid = 1'b1;
            iWriteData  = word.raw;
            accepted    = 1'b0;
            while (!accepted) begin
                checkValue(32'(oChipEnable), 32'(chipMask), "chip enable during transfer");
                checkValue(32'(oWriteEnable), 32'(`WE_WRITE_PATTERN), "write enable in transfer");
                checkValue(32'(oReady), 0, "ready during transfer");
                accepted = oWriteReady;
                if (accepted) begin
                    sentWords.push_back(word);
                    sentCycles.push_back(cycleCount + 1);
                end
                @(negedge iSystemClock);
            end
        end
        iWriteValid = 1'b0;
        lastAccept  = sentCycles[$];
        checkValue(sentCycles[0], startCycle + 2 + `TDQSS_CYCLES, "first word accept edge");
        checkValue(32'(oWriteReady), 0, "write ready after the final word");
        while (!oLastStep) begin
            checkValue(32'(oChipEnable), 32'(chipMask), "chip enable in postamble");
            checkValue(32'(oReady), 0, "ready in postamble");
            @(negedge iSystemClock);
        end
        checkValue(cycleCount, lastAccept + `WPST_CYCLES - 1, "last step position");
        checkValue(32'(oChipEnable), 32'(chipMask), "chip enable with last step");
        @(negedge iSystemClock);
        checkValue(32'(oReady), 1, "ready after last step");
        checkValue(32'(oLastStep), 0, "last step width");
        checkValue(32'(oChipEnable), 0, "chip enable after transfer");
        checkValue(32'(oWriteEnable), 0, "write enable after transfer");
        checkValue(lastStepCount, stepsBefore + 1, "last step pulses per transfer");
        compareBeats();
    endtask

    task automatic testResetState();
        repeat (3) @(negedge iSystemClock);
        checkIdleOutputs("during reset");
        @(negedge iReset);
        checkIdleOutputs("at reset release");
        @(negedge iSystemClock);
        checkValue(32'(oReady), 1, "ready one cycle after reset");
    endtask

    task automatic testSingleWord();
        runTransfer(4'b0101, 1, 0, 1'b0);
    endtask

    task automatic testStreamed();
        runTransfer(4'b0011, 8, 0, 1'b0);
        foreach (seenCycles[i]) begin
            checkValue(seenCycles[i], seenCycles[0] + i, "streamed beats back to back");
        end
    endtask

    task automatic testBackPressure();
        runTransfer(4'b1111, 12, MaxGap, 1'b0);
    endtask

    task automatic testWaySelection();
        logic [Ways-1:0] way;
        int stepsAfter;
        for (int k = 0; k < 3; k++) begin
            way = Ways'($urandom_range(1, (1 << Ways) - 1));
            runTransfer(way, 4, 1, k == 1);  // middle one sees an early start
            stepsAfter = lastStepCount;
            repeat (IdleCycles) @(negedge iSystemClock);
            checkValue(lastStepCount, stepsAfter, "extra last step after ignored start");
            checkValue(32'(oReady), 1, "ready while idle");
            checkValue(32'(oChipEnable), 0, "chip enable while idle");
        end
    endtask

    initial begin
        iStart      = 1'b0;
        iTargetWay  = '0;
        iNumOfData  = '0;
        iWriteData  = '0;
        iWriteValid = 1'b0;
        void'($urandom(16));
        testResetState();
        testSingleWord();
        testStreamed();
        testBackPressure();
        testWaySelection();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
